//--- hw/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // Machine word, used for virtual and physical addresses and PTEs
    typedef logic [31:0] xlen_t;

    // Virtual page number {VPN[1], VPN[0]}
    typedef logic [19:0] vpn_t;

    // One level of the VPN
    typedef logic [9:0]  vpn_idx_t;

    // Physical page number as stored in a PTE
    typedef logic [21:0] ppn_t;

    // Low byte of an Sv32 PTE, V at bit 0
    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    // Privilege levels as encoded in mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_t;

    // Exception causes
    typedef logic [3:0] fault_code_t;

    localparam fault_code_t FAULT_INST_PAGE  = 4'd12;
    localparam fault_code_t FAULT_LOAD_PAGE  = 4'd13;
    localparam fault_code_t FAULT_STORE_PAGE = 4'd15;

    localparam int PAGE_OFFSET_W = 12;
    localparam int PTE_BYTES     = 4;

    // True when the access may use a page with these flags
    // S-mode may touch U pages; A and D are not checked
    function automatic logic pte_perm_ok(
        input pte_flags_t flags,
        input priv_t      priv,
        input logic       is_write,
        input logic       is_execute
    );
        logic ok;
        ok = 1'b1;
        // Reserved encoding
        if (flags.w && !flags.r)
            ok = 1'b0;
        if (priv == PRIV_U && !flags.u)
            ok = 1'b0;
        // Load
        if (!is_write && !is_execute && !flags.r)
            ok = 1'b0;
        // Store
        if (is_write && !flags.w)
            ok = 1'b0;
        // Fetch
        if (is_execute && !flags.x)
            ok = 1'b0;
        return ok;
    endfunction

endpackage

`default_nettype wire

//--- hw/tlb.sv
`timescale 1ns/1ps
`default_nettype none

module tlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire mmu_pkg::vpn_t       lookup_vpn_i,
    output logic                     hit_o,
    output mmu_pkg::ppn_t            hit_ppn_o,
    output mmu_pkg::pte_flags_t      hit_flags_o,
    output logic                     hit_superpage_o,
    input  wire logic                fill_i,
    input  wire mmu_pkg::vpn_t       fill_vpn_i,
    input  wire mmu_pkg::ppn_t       fill_ppn_i,
    input  wire mmu_pkg::pte_flags_t fill_flags_i,
    input  wire logic                fill_superpage_i,
    input  wire logic                flush_all_i
);

    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // Entry storage
    logic [TLB_ENTRIES-1:0] valid_q;
    logic [TLB_ENTRIES-1:0] superpage_q;
    vpn_t                   vpn_q   [TLB_ENTRIES];
    ppn_t                   ppn_q   [TLB_ENTRIES];
    pte_flags_t             flags_q [TLB_ENTRIES];

    // Replacement pointer
    logic [IDX_W-1:0]       rr_ptr_q;

    logic [TLB_ENTRIES-1:0] lookup_match;
    logic [TLB_ENTRIES-1:0] fill_match;
    logic [IDX_W-1:0]       fill_idx;
    logic                   fill_hit;

    // Superpage entries compare VPN[1] only
    function automatic logic entry_match(
        input logic valid,
        input logic superpage,
        input vpn_t entry_vpn,
        input vpn_t vpn
    );
        logic same_vpn1;
        same_vpn1 = (entry_vpn[19:10] == vpn[19:10]);
        if (superpage)
            return valid && same_vpn1;
        return valid && (entry_vpn == vpn);
    endfunction

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            lookup_match[i] = entry_match(valid_q[i], superpage_q[i], vpn_q[i], lookup_vpn_i);
            fill_match[i]   = entry_match(valid_q[i], superpage_q[i], vpn_q[i], fill_vpn_i);
        end
    end

    // Lowest matching entry wins
    always_comb begin
        hit_o           = 1'b0;
        hit_ppn_o       = '0;
        hit_flags_o     = '0;
        hit_superpage_o = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (lookup_match[i]) begin
                hit_o           = 1'b1;
                hit_ppn_o       = ppn_q[i];
                hit_flags_o     = flags_q[i];
                hit_superpage_o = superpage_q[i];
            end
        end
    end

    // Refill in place, else take the round-robin victim
    assign fill_hit = |fill_match;

    always_comb begin
        fill_idx = rr_ptr_q;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (fill_match[i])
                fill_idx = IDX_W'(i);
        end
    end

    // Flush beats a fill in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else if (flush_all_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_idx] <= 1'b1;
            if (!fill_hit)
                rr_ptr_q <= rr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            vpn_q[fill_idx]       <= fill_vpn_i;
            ppn_q[fill_idx]       <= fill_ppn_i;
            flags_q[fill_idx]     <= fill_flags_i;
            superpage_q[fill_idx] <= fill_superpage_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/page_table_walker.sv
`timescale 1ns/1ps
`default_nettype none

module page_table_walker (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           start_i,
    input  wire mmu_pkg::vpn_t  vpn_i,
    input  wire mmu_pkg::ppn_t  root_ppn_i,
    output mmu_pkg::xlen_t      ptw_addr_o,
    output logic                ptw_req_o,
    input  wire mmu_pkg::xlen_t ptw_data_i,
    input  wire logic           ptw_ack_i,
    output logic                done_o,
    output logic                fault_o,
    output mmu_pkg::xlen_t      leaf_pte_o,
    output logic                superpage_o
);

    import mmu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_L1_WAIT,
        ST_L2_WAIT,
        ST_REPORT
    } state_t;

    state_t     state_q;

    // Walk context
    vpn_t       vpn_q;
    ppn_t       base_ppn_q;

    // Result
    xlen_t      leaf_pte_q;
    logic       fault_q;
    logic       superpage_q;

    // Fields of the PTE on the read port
    pte_flags_t data_flags;
    ppn_t       data_ppn;
    logic       data_leaf;
    vpn_idx_t   pte_idx;

    assign data_flags = pte_flags_t'(ptw_data_i[7:0]);
    assign data_ppn   = ptw_data_i[31:10];
    assign data_leaf  = data_flags.r || data_flags.x;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i)
                        state_q <= ST_L1_WAIT;
                end
                ST_L1_WAIT: begin
                    // Valid pointer descends, anything else ends the walk
                    if (ptw_ack_i)
                        state_q <= (data_flags.v && !data_leaf) ? ST_L2_WAIT : ST_REPORT;
                end
                ST_L2_WAIT: begin
                    if (ptw_ack_i)
                        state_q <= ST_REPORT;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    vpn_q      <= vpn_i;
                    base_ppn_q <= root_ppn_i;
                end
            end
            ST_L1_WAIT: begin
                if (ptw_ack_i) begin
                    // Next table base when this is a pointer
                    base_ppn_q  <= data_ppn;
                    leaf_pte_q  <= ptw_data_i;
                    superpage_q <= 1'b1;
                    // Superpage must be 4 MB aligned
                    fault_q     <= !data_flags.v || (data_leaf && data_ppn[9:0] != '0);
                end
            end
            ST_L2_WAIT: begin
                if (ptw_ack_i) begin
                    leaf_pte_q  <= ptw_data_i;
                    superpage_q <= 1'b0;
                    fault_q     <= !data_flags.v || !data_leaf;
                end
            end
            default: begin
            end
        endcase
    end

    // PTE address is base * page size + index * PTE size
    assign pte_idx    = (state_q == ST_L2_WAIT) ? vpn_q[9:0] : vpn_q[19:10];
    assign ptw_addr_o = xlen_t'({base_ppn_q, {PAGE_OFFSET_W{1'b0}}})
                      + xlen_t'(pte_idx) * xlen_t'(PTE_BYTES);
    assign ptw_req_o  = (state_q == ST_L1_WAIT) || (state_q == ST_L2_WAIT);

    assign done_o      = (state_q == ST_REPORT);
    assign fault_o     = fault_q;
    assign leaf_pte_o  = leaf_pte_q;
    assign superpage_o = superpage_q;

endmodule

`default_nettype wire

//--- hw/mmu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_ctrl (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire mmu_pkg::xlen_t      satp_i,
    input  wire mmu_pkg::priv_t      priv_mode_i,
    input  wire logic                translate_req_i,
    input  wire logic                is_write_i,
    input  wire logic                is_execute_i,
    input  wire mmu_pkg::xlen_t      vaddr_i,
    output mmu_pkg::xlen_t           paddr_o,
    output logic                     translate_done_o,
    output logic                     page_fault_o,
    output mmu_pkg::fault_code_t     fault_code_o,
    output mmu_pkg::vpn_t            lookup_vpn_o,
    input  wire logic                hit_i,
    input  wire mmu_pkg::ppn_t       hit_ppn_i,
    input  wire mmu_pkg::pte_flags_t hit_flags_i,
    input  wire logic                hit_superpage_i,
    output logic                     fill_o,
    output mmu_pkg::vpn_t            fill_vpn_o,
    output mmu_pkg::ppn_t            fill_ppn_o,
    output mmu_pkg::pte_flags_t      fill_flags_o,
    output logic                     fill_superpage_o,
    output logic                     walk_start_o,
    output mmu_pkg::vpn_t            walk_vpn_o,
    input  wire logic                walk_done_i,
    input  wire logic                walk_fault_i,
    input  wire mmu_pkg::xlen_t      walk_pte_i,
    input  wire logic                walk_superpage_i
);

    import mmu_pkg::*;

    // Walk in flight
    logic        busy_q;
    logic        paging_on;
    logic        hit_perm_ok;
    logic        walk_perm_ok;
    pte_flags_t  walk_flags;
    ppn_t        walk_ppn;
    fault_code_t access_code;

    // Superpage keeps VPN[0] from the virtual address
    function automatic xlen_t form_paddr(
        input ppn_t  ppn,
        input logic  superpage,
        input xlen_t vaddr
    );
        logic [33:0] full;
        if (superpage)
            full = {ppn[21:10], vaddr[21:0]};
        else
            full = {ppn, vaddr[PAGE_OFFSET_W-1:0]};
        return full[31:0];
    endfunction

    assign paging_on  = satp_i[31];
    assign walk_flags = pte_flags_t'(walk_pte_i[7:0]);
    assign walk_ppn   = walk_pte_i[31:10];

    assign hit_perm_ok  = pte_perm_ok(hit_flags_i, priv_mode_i, is_write_i, is_execute_i);
    assign walk_perm_ok = pte_perm_ok(walk_flags, priv_mode_i, is_write_i, is_execute_i);

    // Fetch first, then store, then load
    assign access_code = is_execute_i ? FAULT_INST_PAGE :
                         is_write_i   ? FAULT_STORE_PAGE : FAULT_LOAD_PAGE;

    // Request fields stay stable until done, so no copy is kept
    assign lookup_vpn_o = vaddr_i[31:12];
    assign walk_vpn_o   = vaddr_i[31:12];

    // TLB refill straight from the leaf
    assign fill_vpn_o       = vaddr_i[31:12];
    assign fill_ppn_o       = walk_ppn;
    assign fill_flags_o     = walk_flags;
    assign fill_superpage_o = walk_superpage_i;

    always_comb begin
        paddr_o          = '0;
        translate_done_o = 1'b0;
        page_fault_o     = 1'b0;
        fault_code_o     = '0;
        walk_start_o     = 1'b0;
        fill_o           = 1'b0;
        if (walk_done_i) begin
            // Walk result, TLB written on this edge
            translate_done_o = 1'b1;
            if (walk_fault_i || !walk_perm_ok) begin
                page_fault_o = 1'b1;
                fault_code_o = access_code;
            end else begin
                paddr_o = form_paddr(walk_ppn, walk_superpage_i, vaddr_i);
                fill_o  = 1'b1;
            end
        end else if (translate_req_i && !busy_q) begin
            if (!paging_on) begin
                // Bare mode
                paddr_o          = vaddr_i;
                translate_done_o = 1'b1;
            end else if (hit_i) begin
                translate_done_o = 1'b1;
                if (hit_perm_ok) begin
                    paddr_o = form_paddr(hit_ppn_i, hit_superpage_i, vaddr_i);
                end else begin
                    page_fault_o = 1'b1;
                    fault_code_o = access_code;
                end
            end else begin
                // Miss
                walk_start_o = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            busy_q <= 1'b0;
        else if (walk_start_o)
            busy_q <= 1'b1;
        else if (walk_done_i)
            busy_q <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/sv32_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module sv32_mmu #(
    parameter int TLB_ENTRIES = 8
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire mmu_pkg::xlen_t  satp_i,
    input  wire mmu_pkg::priv_t  priv_mode_i,
    input  wire logic            translate_req_i,
    input  wire logic            is_write_i,
    input  wire logic            is_execute_i,
    input  wire mmu_pkg::xlen_t  vaddr_i,
    output mmu_pkg::xlen_t       paddr_o,
    output logic                 translate_done_o,
    output logic                 page_fault_o,
    output mmu_pkg::fault_code_t fault_code_o,
    output mmu_pkg::xlen_t       ptw_addr_o,
    output logic                 ptw_req_o,
    input  wire mmu_pkg::xlen_t  ptw_data_i,
    input  wire logic            ptw_ack_i,
    input  wire logic            flush_all_i
);

    import mmu_pkg::*;

    // TLB lookup
    vpn_t       lookup_vpn;
    logic       tlb_hit;
    ppn_t       tlb_hit_ppn;
    pte_flags_t tlb_hit_flags;
    logic       tlb_hit_superpage;

    // TLB fill
    logic       tlb_fill;
    vpn_t       tlb_fill_vpn;
    ppn_t       tlb_fill_ppn;
    pte_flags_t tlb_fill_flags;
    logic       tlb_fill_superpage;

    // Walker handshake
    logic       walk_start;
    vpn_t       walk_vpn;
    logic       walk_done;
    logic       walk_fault;
    xlen_t      walk_pte;
    logic       walk_superpage;

    mmu_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .satp_i           (satp_i),
        .priv_mode_i      (priv_mode_i),
        .translate_req_i  (translate_req_i),
        .is_write_i       (is_write_i),
        .is_execute_i     (is_execute_i),
        .vaddr_i          (vaddr_i),
        .paddr_o          (paddr_o),
        .translate_done_o (translate_done_o),
        .page_fault_o     (page_fault_o),
        .fault_code_o     (fault_code_o),
        .lookup_vpn_o     (lookup_vpn),
        .hit_i            (tlb_hit),
        .hit_ppn_i        (tlb_hit_ppn),
        .hit_flags_i      (tlb_hit_flags),
        .hit_superpage_i  (tlb_hit_superpage),
        .fill_o           (tlb_fill),
        .fill_vpn_o       (tlb_fill_vpn),
        .fill_ppn_o       (tlb_fill_ppn),
        .fill_flags_o     (tlb_fill_flags),
        .fill_superpage_o (tlb_fill_superpage),
        .walk_start_o     (walk_start),
        .walk_vpn_o       (walk_vpn),
        .walk_done_i      (walk_done),
        .walk_fault_i     (walk_fault),
        .walk_pte_i       (walk_pte),
        .walk_superpage_i (walk_superpage)
    );

    tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk              (clk),
        .rst              (rst),
        .lookup_vpn_i     (lookup_vpn),
        .hit_o            (tlb_hit),
        .hit_ppn_o        (tlb_hit_ppn),
        .hit_flags_o      (tlb_hit_flags),
        .hit_superpage_o  (tlb_hit_superpage),
        .fill_i           (tlb_fill),
        .fill_vpn_i       (tlb_fill_vpn),
        .fill_ppn_i       (tlb_fill_ppn),
        .fill_flags_i     (tlb_fill_flags),
        .fill_superpage_i (tlb_fill_superpage),
        .flush_all_i      (flush_all_i)
    );

    // Root table from satp.PPN
    page_table_walker u_ptw (
        .clk         (clk),
        .rst         (rst),
        .start_i     (walk_start),
        .vpn_i       (walk_vpn),
        .root_ppn_i  (satp_i[21:0]),
        .ptw_addr_o  (ptw_addr_o),
        .ptw_req_o   (ptw_req_o),
        .ptw_data_i  (ptw_data_i),
        .ptw_ack_i   (ptw_ack_i),
        .done_o      (walk_done),
        .fault_o     (walk_fault),
        .leaf_pte_o  (walk_pte),
        .superpage_o (walk_superpage)
    );

endmodule

`default_nettype wire

//--- tb/sv32_mmu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sv32_mmu_assert (
    input wire logic           clk,
    input wire logic           rst,
    input wire mmu_pkg::xlen_t satp_i,
    input wire logic           translate_req_i,
    input wire logic           translate_done_o,
    input wire mmu_pkg::xlen_t ptw_addr_o,
    input wire logic           ptw_req_o,
    input wire logic           ptw_ack_i
);

    // Failed assertions so far
    int fail_count = 0;

    // Done only answers a live request
    done_needs_req: assert property (@(posedge clk) disable iff (rst)
        translate_done_o |-> translate_req_i)
        else begin
            fail_count++;
            $error("translate_done_o high without translate_req_i");
        end

    // Read held until acked
    walk_addr_held: assert property (@(posedge clk) disable iff (rst)
        ptw_req_o && !ptw_ack_i |=> ptw_req_o && $stable(ptw_addr_o))
        else begin
            fail_count++;
            $error("ptw_req_o or ptw_addr_o changed before ptw_ack_i");
        end

    // Bare mode never walks
    no_walk_bare: assert property (@(posedge clk) disable iff (rst)
        !satp_i[31] |-> !ptw_req_o)
        else begin
            fail_count++;
            $error("ptw_req_o high with satp MODE clear");
        end

endmodule

bind sv32_mmu sv32_mmu_assert u_assert (
    .clk              (clk),
    .rst              (rst),
    .satp_i           (satp_i),
    .translate_req_i  (translate_req_i),
    .translate_done_o (translate_done_o),
    .ptw_addr_o       (ptw_addr_o),
    .ptw_req_o        (ptw_req_o),
    .ptw_ack_i        (ptw_ack_i)
);

`default_nettype wire

//--- tb/tb_sv32_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sv32_mmu;

    import mmu_pkg::*;

    localparam int   CLK_PERIOD     = 20;
    localparam int   TLB_ENTRIES    = 8;
    localparam int   TIMEOUT_CYCLES = 100;
    localparam int   SEED           = 14954;
    localparam ppn_t ROOT_PPN       = 22'h00100;

    // PTE flag bytes
    localparam logic [7:0] F_V  = 8'h01;
    localparam logic [7:0] F_R  = 8'h02;
    localparam logic [7:0] F_W  = 8'h04;
    localparam logic [7:0] F_X  = 8'h08;
    localparam logic [7:0] F_U  = 8'h10;
    localparam logic [7:0] F_AD = 8'hc0;

    logic        clk;
    logic        rst;
    xlen_t       satp;
    priv_t       priv_mode;
    logic        translate_req;
    logic        is_write;
    logic        is_execute;
    xlen_t       vaddr;
    xlen_t       paddr;
    logic        translate_done;
    logic        page_fault;
    fault_code_t fault_code;
    xlen_t       ptw_addr;
    logic        ptw_req;
    xlen_t       ptw_data;
    logic        ptw_ack;
    logic        flush_all;

    // Page tables, keyed by byte address; absent words read as invalid PTEs
    xlen_t       page_mem [xlen_t];

    // Expected result of the current request
    xlen_t       exp_paddr;
    logic        exp_fault;
    fault_code_t exp_code;
    logic        done_seen = 1'b0;
    int          lat_cnt = 0;
    int          done_latency = 0;
    int          walk_reads = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          failed_tests = 0;

    sv32_mmu #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) sv32_mmu_i (
        .clk              (clk),
        .rst              (rst),
        .satp_i           (satp),
        .priv_mode_i      (priv_mode),
        .translate_req_i  (translate_req),
        .is_write_i       (is_write),
        .is_execute_i     (is_execute),
        .vaddr_i          (vaddr),
        .paddr_o          (paddr),
        .translate_done_o (translate_done),
        .page_fault_o     (page_fault),
        .fault_code_o     (fault_code),
        .ptw_addr_o       (ptw_addr),
        .ptw_req_o        (ptw_req),
        .ptw_data_i       (ptw_data),
        .ptw_ack_i        (ptw_ack),
        .flush_all_i      (flush_all)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic xlen_t pt_read(input xlen_t addr);
        if (page_mem.exists(addr))
            return page_mem[addr];
        return '0;
    endfunction

    function automatic xlen_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    // Root table entry for one VPN[1]
    function automatic xlen_t l1_addr(input vpn_idx_t vpn1);
        logic [33:0] addr;
        addr = {ROOT_PPN, 12'h000} + {22'h0, vpn1, 2'b00};
        return addr[31:0];
    endfunction

    // One level-2 table per VPN[1]
    function automatic ppn_t l2_table(input vpn_idx_t vpn1);
        return 22'h00200 + 22'(vpn1);
    endfunction

    // Pointer at level 1, given PTE at level 2
    task automatic set_leaf4k(input xlen_t va, input xlen_t pte);
        ppn_t        tbl;
        logic [33:0] addr;
        tbl  = l2_table(va[31:22]);
        addr = {tbl, 12'h000} + {22'h0, va[21:12], 2'b00};
        page_mem[l1_addr(va[31:22])] = make_pte(tbl, F_V);
        page_mem[addr[31:0]]         = pte;
    endtask

    // Sv32 leaf rules, S-mode may use U pages
    function automatic logic access_allowed(
        input logic [7:0] flags,
        input logic       wr,
        input logic       ex,
        input priv_t      priv
    );
        logic r;
        logic w;
        logic x;
        logic u;
        r = |(flags & F_R);
        w = |(flags & F_W);
        x = |(flags & F_X);
        u = |(flags & F_U);
        // W without R is reserved
        if (w && !r)
            return 1'b0;
        if (priv == PRIV_U && !u)
            return 1'b0;
        if (ex)
            return x;
        if (wr)
            return w;
        return r;
    endfunction

    // Sv32 translation from the spec, over the same page tables
    function automatic void ref_translate(
        input  xlen_t       va,
        input  logic        wr,
        input  logic        ex,
        input  priv_t       priv,
        output xlen_t       pa,
        output logic        fault,
        output fault_code_t code
    );
        logic [33:0] pte_addr;
        logic [33:0] pa_full;
        xlen_t       pte;
        code = ex ? FAULT_INST_PAGE : (wr ? FAULT_STORE_PAGE : FAULT_LOAD_PAGE);
        if (!satp[31]) begin
            pa    = va;
            fault = 1'b0;
        end else begin
            pte_addr = {satp[21:0], 12'h000} + 34'(va[31:22]) * 34'(PTE_BYTES);
            pte      = pt_read(pte_addr[31:0]);
            pa_full  = '0;
            if (pte[0] && (pte[1] || pte[3])) begin
                // 4 MB leaf needs PPN[0] clear
                fault   = (pte[19:10] != 10'h0);
                pa_full = {pte[31:20], va[21:0]};
            end else if (pte[0]) begin
                pte_addr = {pte[31:10], 12'h000} + 34'(va[21:12]) * 34'(PTE_BYTES);
                pte      = pt_read(pte_addr[31:0]);
                fault    = !(pte[0] && (pte[1] || pte[3]));
                pa_full  = {pte[31:10], va[11:0]};
            end else begin
                fault = 1'b1;
            end
            if (!fault)
                fault = !access_allowed(pte[7:0], wr, ex, priv);
            pa = pa_full[31:0];
        end
    endfunction

    task automatic check_addr(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error: %0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_fault(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_code(input string name, input fault_code_t got, input fault_code_t exp);
        if (got !== exp) begin
            $display("Error: %0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Memory read port, 0 to 3 cycles before each ack
    initial begin : memory_model
        int   delay;
        logic pending;
        delay    = 0;
        pending  = 1'b0;
        ptw_ack  = 1'b0;
        ptw_data = '0;
        forever begin
            @(negedge clk);
            ptw_ack = 1'b0;
            if (ptw_req) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = int'($urandom % 4);
                end
                if (delay == 0) begin
                    ptw_data = pt_read(ptw_addr);
                    ptw_ack  = 1'b1;
                    pending  = 1'b0;
                    walk_reads++;
                end else begin
                    delay--;
                end
            end
        end
    end

    // Mid low phase, outputs have settled
    initial begin : compare_results
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            if (translate_req && !done_seen) begin
                if (translate_done) begin
                    check_fault("page_fault_o", page_fault, exp_fault);
                    if (exp_fault)
                        check_code("fault_code_o", fault_code, exp_code);
                    else
                        check_addr("paddr_o", paddr, exp_paddr);
                    done_latency = lat_cnt;
                    done_seen    = 1'b1;
                end else begin
                    lat_cnt++;
                end
            end
        end
    end

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done_seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    // Negative want values skip that check
    task automatic run_access(
        input string label,
        input xlen_t va,
        input logic  wr,
        input logic  ex,
        input priv_t priv,
        input int    want_latency,
        input int    want_reads
    );
        int errors_before;
        int reads_before;
        errors_before = error_count;
        ref_translate(va, wr, ex, priv, exp_paddr, exp_fault, exp_code);
        @(negedge clk);
        reads_before  = walk_reads;
        vaddr         = va;
        is_write      = wr;
        is_execute    = ex;
        priv_mode     = priv;
        done_seen     = 1'b0;
        lat_cnt       = 0;
        translate_req = 1'b1;
        wait_done();
        translate_req = 1'b0;
        if (!done_seen) begin
            $display("Timeout: no translate_done_o for %s within %0d cycles",
                     label, TIMEOUT_CYCLES);
            error_count++;
        end else begin
            if (want_latency >= 0 && done_latency != want_latency) begin
                $display("%s: done came %0d cycles after the request, expected %0d",
                         label, done_latency, want_latency);
                error_count++;
            end
            if (want_reads >= 0 && walk_reads - reads_before != want_reads) begin
                $display("%s: %0d page table reads, expected %0d",
                         label, walk_reads - reads_before, want_reads);
                error_count++;
            end
        end
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s va %h: pass", test_count, label, va);
        end else begin
            failed_tests++;
            $display("test %0d %s va %h: fail", test_count, label, va);
        end
    endtask

    task automatic flush_tlb();
        @(negedge clk);
        flush_all = 1'b1;
        @(negedge clk);
        flush_all = 1'b0;
    endtask

    initial begin : stimulus
        xlen_t va;
        ppn_t  ppn;
        int    assert_fails;
        void'($urandom(SEED));
        rst           = 1'b1;
        satp          = '0;
        priv_mode     = PRIV_S;
        translate_req = 1'b0;
        is_write      = 1'b0;
        is_execute    = 1'b0;
        vaddr         = '0;
        flush_all     = 1'b0;
        // Two rising edges in reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Bare mode, same cycle and no reads
        for (int i = 0; i < 4; i++)
            run_access("bare", $urandom, i[0], 1'b0, PRIV_S, 0, 0);

        satp = {1'b1, 9'h0, ROOT_PPN};

        // 4 KB pages
        for (int i = 0; i < 6; i++) begin
            va  = {10'(16 + i), 10'($urandom), 12'($urandom)};
            ppn = {2'b00, 20'($urandom)};
            set_leaf4k(va, make_pte(ppn, F_V | F_R | F_W | F_X | F_AD));
            run_access("page 4k", va, i[0], 1'b0, PRIV_S, -1, 2);
        end

        // 4 MB superpages
        for (int i = 0; i < 3; i++) begin
            va  = {10'(40 + i), 22'($urandom)};
            ppn = {12'($urandom), 10'h000};
            page_mem[l1_addr(va[31:22])] = make_pte(ppn, F_V | F_R | F_X | F_AD);
            run_access("superpage", va, 1'b0, i[0], PRIV_S, -1, 1);
        end

        // Structural faults
        va = {10'd60, 22'($urandom)};
        run_access("invalid pte", va, 1'b0, 1'b0, PRIV_S, -1, 1);
        va = {10'd61, 22'($urandom)};
        page_mem[l1_addr(va[31:22])] = make_pte(22'h000401, F_V | F_R | F_W | F_X | F_AD);
        run_access("misaligned superpage", va, 1'b1, 1'b0, PRIV_S, -1, 1);
        va = {10'd62, 22'($urandom)};
        set_leaf4k(va, make_pte(22'h00345, F_V));
        run_access("level 2 pointer", va, 1'b0, 1'b1, PRIV_S, -1, 2);
        va = {10'd63, 22'($urandom)};
        set_leaf4k(va, make_pte(22'h00346, F_V | F_W | F_X | F_AD));
        run_access("w without r", va, 1'b0, 1'b1, PRIV_S, -1, 2);

        // Permission faults
        va = {10'd70, 22'($urandom)};
        set_leaf4k(va, make_pte(22'h00470, F_V | F_R | F_W | F_X | F_AD));
        run_access("user on s page", va, 1'b0, 1'b0, PRIV_U, -1, 2);
        va = {10'd71, 22'($urandom)};
        set_leaf4k(va, make_pte(22'h00471, F_V | F_R | F_AD));
        run_access("store read-only", va, 1'b1, 1'b0, PRIV_S, -1, 2);
        va = {10'd72, 22'($urandom)};
        set_leaf4k(va, make_pte(22'h00472, F_V | F_R | F_W | F_AD));
        run_access("fetch no x", va, 1'b0, 1'b1, PRIV_S, -1, 2);
        va = {10'd73, 22'($urandom)};
        set_leaf4k(va, make_pte(22'h00473, F_V | F_R | F_W | F_U | F_AD));
        run_access("s on u page", va, 1'b0, 1'b0, PRIV_S, -1, 2);

        // TLB hit, then flush forces a new walk
        va = {10'd80, 22'($urandom)};
        set_leaf4k(va, make_pte(22'h00480, F_V | F_R | F_W | F_AD));
        run_access("tlb fill", va, 1'b0, 1'b0, PRIV_S, -1, 2);
        run_access("tlb hit", va, 1'b1, 1'b0, PRIV_S, 0, 0);
        run_access("tlb hit fetch fault", va, 1'b0, 1'b1, PRIV_S, 0, 0);
        flush_tlb();
        run_access("after flush", va, 1'b0, 1'b0, PRIV_S, -1, 2);

        assert_fails = sv32_mmu_i.u_assert.fail_count;
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 test_count, test_count - failed_tests, failed_tests, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/mmu_pkg.sv
hw/tlb.sv
hw/page_table_walker.sv
hw/mmu_ctrl.sv
hw/sv32_mmu.sv
tb/sv32_mmu_assert.sv
tb/tb_sv32_mmu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_sv32_mmu
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST OK
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)
RUN_FLAGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
